/* back_end.f */
rtl/bk_pkg.sv
rtl/gpr_stage.sv
rtl/exec_unit.sv
rtl/lsu.sv
rtl/writeback.sv
rtl/back_end.sv
test/data_mem_model.sv
test/back_end_checker.sv
test/back_end_asserts.sv
test/back_end_tb.sv

/* Bender.yml */
package:
  name: back_end

sources:
  - rtl/bk_pkg.sv
  - rtl/gpr_stage.sv
  - rtl/exec_unit.sv
  - rtl/lsu.sv
  - rtl/writeback.sv
  - rtl/back_end.sv
  - target: test
    files:
      - test/data_mem_model.sv
      - test/back_end_checker.sv
      - test/back_end_asserts.sv
      - test/back_end_tb.sv

/* test/back_end_tb.sv */
`timescale 1ns/1ps

module back_end_tb;
	import bk_pkg::*;

	localparam int ISSUE_LIMIT = 200;
	localparam int DRAIN_LIMIT = 500;

	logic clk = 1'b0;
	logic arst_n;
	logic in_valid;
	logic [WARP_W-1:0] in_warp;
	logic [OP_W-1:0] in_op;
	logic [REG_W-1:0] in_rd;
	logic [REG_W-1:0] in_rs1;
	logic [REG_W-1:0] in_rs2;
	logic [XLEN-1:0] in_imm;
	logic [XLEN-1:0] in_pc;
	logic in_ready;
	logic br_valid;
	logic [WARP_W-1:0] br_warp;
	logic br_taken;
	logic [XLEN-1:0] br_dest;
	logic wb_valid;
	logic [WARP_W-1:0] wb_warp;
	logic [REG_W-1:0] wb_rd;
	logic [XLEN-1:0] wb_data;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [XLEN-1:0] wb_adr;
	logic [XLEN-1:0] wb_dat_w;
	logic [SEL_W-1:0] wb_sel;
	logic [XLEN-1:0] wb_dat_r;
	logic wb_ack;
	logic [8*16-1:0] test_name;
	logic count_check;
	logic timed_out;
	int errors;
	int outstanding;
	int wb_seen;
	int wb_expected;
	int base_errors;
	int tests_run;

	always #20 clk = ~clk;

	back_end dut (.*);

	data_mem_model u_mem (
		.clk    (clk),
		.arst_n (arst_n),
		.cyc    (wb_cyc),
		.stb    (wb_stb),
		.we     (wb_we),
		.adr    (wb_adr),
		.dat_w  (wb_dat_w),
		.sel    (wb_sel),
		.dat_r  (wb_dat_r),
		.ack    (wb_ack)
	);

	back_end_checker u_checker (.*);

	// ########################################
	// drive and wait
	// ########################################

	task automatic issue(input logic [WARP_W-1:0] warp, input logic [OP_W-1:0] op,
		input logic [REG_W-1:0] rd, input logic [REG_W-1:0] rs1,
		input logic [REG_W-1:0] rs2, input logic [XLEN-1:0] imm,
		input logic [XLEN-1:0] pc);
		int cycles;
		logic done;
		cycles = 0;
		done = 1'b0;
		if (timed_out)
			return;
		in_valid = 1'b1;
		in_warp  = warp;
		in_op    = op;
		in_rd    = rd;
		in_rs1   = rs1;
		in_rs2   = rs2;
		in_imm   = imm;
		in_pc    = pc;
		while (!done) begin
			@(posedge clk);
			if (in_ready) begin
				done = 1'b1;
			end else if (cycles == ISSUE_LIMIT) begin
				$display("timeout: instruction in warp %0d was not accepted within %0d cycles",
					warp, ISSUE_LIMIT);
				timed_out = 1'b1;
				done = 1'b1;
			end
			cycles++;
		end
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		if (timed_out)
			return;
		@(negedge clk);
		while (outstanding != 0) begin
			if (cycles == DRAIN_LIMIT) begin
				$display("timeout: %0d operations still outstanding after %0d cycles",
					outstanding, DRAIN_LIMIT);
				timed_out = 1'b1;
				return;
			end
			cycles++;
			@(negedge clk);
		end
	endtask

	task automatic start_test(input logic [8*16-1:0] name);
		test_name = name;
		base_errors = errors;
	endtask

	task automatic end_test();
		wait_drain();
		tests_run++;
		if (timed_out)
			$display("test %0s: not completed", test_name);
		else if (errors == base_errors)
			$display("test %0s: ok", test_name);
		else
			$display("test %0s: %0d errors", test_name, errors - base_errors);
	endtask

	// ########################################
	// tests
	// ########################################

	task automatic alu_ops();
		start_test("alu");
		for (int w = 0; w < NUM_WARPS; w++) begin
			issue(WARP_W'(w), OP_ADDI, 1, 0, 0, XLEN'(w * 16 + 5), 0);
			issue(WARP_W'(w), OP_ADDI, 2, 0, 0, -32'd7, 0);
			issue(WARP_W'(w), OP_ADD, 3, 1, 2, 0, 0);
			issue(WARP_W'(w), OP_SUB, 4, 1, 2, 0, 0);
			issue(WARP_W'(w), OP_AND, 5, 3, 4, 0, 0);
			issue(WARP_W'(w), OP_OR, 6, 3, 4, 0, 0);
			issue(WARP_W'(w), OP_XOR, 7, 5, 6, 0, 0);
			issue(WARP_W'(w), OP_ADDI, 0, 7, 0, 32'h100, 0);
			issue(WARP_W'(w), OP_ADD, 0, 1, 2, 0, 0);
		end
		end_test();
	endtask

	task automatic store_then_load();
		start_test("store_load");
		for (int w = 0; w < NUM_WARPS; w++) begin
			issue(WARP_W'(w), OP_ADDI, 1, 0, 0, XLEN'(32'h40 + w * 8), 0);
			issue(WARP_W'(w), OP_ADDI, 2, 0, 0, XLEN'(32'hcafe_0000 + w), 0);
			issue(WARP_W'(w), OP_SW, 6, 1, 2, 4, 0);
			issue(WARP_W'(w), OP_LW, 3, 1, 0, 4, 0);
			issue(WARP_W'(w), OP_LW, 4, 0, 0, XLEN'(32'h200 + w * 4), 0);
			issue(WARP_W'(w), OP_ADD, 5, 3, 4, 0, 0);
		end
		end_test();
	endtask

	task automatic branch_outcomes();
		start_test("branch");
		for (int w = 0; w < NUM_WARPS; w++) begin
			issue(WARP_W'(w), OP_ADDI, 1, 0, 0, 5, 0);
			issue(WARP_W'(w), OP_ADDI, 2, 0, 0, 5, 0);
			issue(WARP_W'(w), OP_ADDI, 3, 0, 0, 6, 0);
			issue(WARP_W'(w), OP_BEQ, 6, 1, 2, 32'h20, XLEN'(32'h100 + w * 64));
			issue(WARP_W'(w), OP_BEQ, 6, 1, 3, -32'd8, 32'h200);
			issue(WARP_W'(w), OP_BEQ, 0, 0, 0, 32'h40, 32'h300);
		end
		end_test();
	endtask

	task automatic dependent_chains();
		start_test("chain");
		for (int w = 0; w < NUM_WARPS; w++) begin
			for (int k = 0; k < 6; k++) begin
				issue(WARP_W'(w), OP_ADDI, 1, 1, 0, XLEN'(k + 1), 0);
			end
			issue(WARP_W'(w), OP_SW, 0, 0, 1, XLEN'(32'h100 + w * 4), 0);
			issue(WARP_W'(w), OP_LW, 2, 0, 0, XLEN'(32'h100 + w * 4), 0);
			issue(WARP_W'(w), OP_ADD, 3, 2, 1, 0, 0);
			issue(WARP_W'(w), OP_LW, 3, 0, 0, XLEN'(32'h100 + w * 4), 0);
			issue(WARP_W'(w), OP_SUB, 4, 3, 2, 0, 0);
		end
		end_test();
	endtask

	task automatic random_stream();
		logic [OP_W-1:0] op;
		start_test("random");
		for (int n = 0; n < 200; n++) begin
			op = OP_W'($urandom_range(8, 0));
			issue(WARP_W'($urandom_range(3, 0)), op, REG_W'($urandom_range(7, 0)),
				REG_W'($urandom_range(7, 0)), REG_W'($urandom_range(7, 0)),
				$urandom, $urandom);
		end
		wait_drain();
		count_check = 1'b1;
		@(negedge clk);
		count_check = 1'b0;
		end_test();
	endtask

	initial begin
		void'($urandom(64));
		arst_n      = 1'b1;
		in_valid    = 1'b0;
		in_warp     = '0;
		in_op       = '0;
		in_rd       = '0;
		in_rs1      = '0;
		in_rs2      = '0;
		in_imm      = '0;
		in_pc       = '0;
		count_check = 1'b0;
		timed_out   = 1'b0;
		tests_run   = 0;
		test_name   = "reset";
		#1 arst_n = 1'b0;
		repeat (8) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		alu_ops();
		store_then_load();
		branch_outcomes();
		dependent_chains();
		random_stream();
		$display("tests %0d, writebacks %0d of %0d expected, errors %0d", tests_run,
			wb_seen, wb_expected, errors);
		if ((errors == 0) && !timed_out)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* test/back_end_asserts.sv */
`timescale 1ns/1ps

module back_end_asserts (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     in_ready,
	input  logic                     br_valid,
	input  logic                     wb_valid,
	input  logic [bk_pkg::REG_W-1:0]  wb_rd,
	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic [bk_pkg::XLEN-1:0]   wb_adr,
	input  logic                     wb_ack
);

	// a Wishbone request holds its address until the slave acknowledges
	a_bus_held: assert property (@(posedge clk) disable iff (!arst_n)
		(wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
		else $error("wishbone request dropped or changed before ack");

	a_no_r0_write: assert property (@(posedge clk) disable iff (!arst_n)
		wb_valid |-> (wb_rd != '0))
		else $error("writeback names register 0");

	a_reset_quiet: assert property (@(posedge clk)
		!arst_n |-> !(in_ready || br_valid || wb_valid || wb_cyc || wb_stb))
		else $error("outputs active during reset");

endmodule

bind back_end back_end_asserts u_back_end_asserts (.*);

/* test/back_end_checker.sv */
`timescale 1ns/1ps

module back_end_checker (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic [8*16-1:0]          test_name,
	input  logic                     count_check,
	input  logic                     in_valid,
	input  logic                     in_ready,
	input  logic [bk_pkg::WARP_W-1:0] in_warp,
	input  logic [bk_pkg::OP_W-1:0]   in_op,
	input  logic [bk_pkg::REG_W-1:0]  in_rd,
	input  logic [bk_pkg::REG_W-1:0]  in_rs1,
	input  logic [bk_pkg::REG_W-1:0]  in_rs2,
	input  logic [bk_pkg::XLEN-1:0]   in_imm,
	input  logic [bk_pkg::XLEN-1:0]   in_pc,
	input  logic                     wb_valid,
	input  logic [bk_pkg::WARP_W-1:0] wb_warp,
	input  logic [bk_pkg::REG_W-1:0]  wb_rd,
	input  logic [bk_pkg::XLEN-1:0]   wb_data,
	input  logic                     br_valid,
	input  logic [bk_pkg::WARP_W-1:0] br_warp,
	input  logic                     br_taken,
	input  logic [bk_pkg::XLEN-1:0]   br_dest,
	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_ack,
	output int                       errors,
	output int                       outstanding,
	output int                       wb_seen,
	output int                       wb_expected
);
	import bk_pkg::*;

	localparam int RES_W = WARP_W + REG_W + XLEN;
	localparam int BR_W  = WARP_W + 1 + XLEN;

	logic [XLEN-1:0] ref_rf [NUM_WARPS][NUM_REGS];
	logic [XLEN-1:0] ref_mem [256];
	logic [RES_W-1:0] res_q [$];
	logic [BR_W-1:0] br_q [$];
	logic [BR_W-1:0] br_exp;
	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] addr;
	logic [XLEN-1:0] result;
	int mem_issued;
	int mem_acked;
	int hit;

	// expected register value of an instruction from its operands
	function automatic logic [XLEN-1:0] expect_result(input logic [OP_W-1:0] op,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
		input logic [XLEN-1:0] imm, input logic [XLEN-1:0] mem_word);
		logic [XLEN-1:0] r;
		case (op)
			OP_ADD:  r = a + b;
			OP_SUB:  r = a - b;
			OP_AND:  r = a & b;
			OP_OR:   r = a | b;
			OP_XOR:  r = a ^ b;
			OP_ADDI: r = a + imm;
			OP_LW:   r = mem_word;
			default: r = '0;
		endcase
		return r;
	endfunction

	always @(posedge clk) begin
		if (!arst_n) begin
			for (int w = 0; w < NUM_WARPS; w++) begin
				for (int r = 0; r < NUM_REGS; r++) begin
					ref_rf[w][r] = '0;
				end
			end
			for (int i = 0; i < 256; i++) begin
				ref_mem[i] = 32'hd00d_0000 ^ (i * 32'h0001_0103);
			end
			res_q.delete();
			br_q.delete();
			errors      = 0;
			outstanding = 0;
			wb_seen     = 0;
			wb_expected = 0;
			mem_issued  = 0;
			mem_acked   = 0;
		end else begin
			// ########################################
			// results leaving the DUT
			// ########################################
			if (wb_valid) begin
				wb_seen++;
				hit = -1;
				for (int i = res_q.size() - 1; i >= 0; i--) begin
					if (res_q[i][XLEN +: WARP_W+REG_W] == {wb_warp, wb_rd})
						hit = i;
				end
				if (hit < 0) begin
					errors++;
					$display("%0s: unexpected writeback to warp %0d r%0d", test_name,
						wb_warp, wb_rd);
				end else begin
					if (res_q[hit][XLEN-1:0] !== wb_data) begin
						errors++;
						$display("CHECK FAILED %0s: warp %0d r%0d expected %h actual %h",
							test_name, wb_warp, wb_rd, res_q[hit][XLEN-1:0], wb_data);
					end
					res_q.delete(hit);
				end
			end
			if (br_valid) begin
				if (br_q.size() == 0) begin
					errors++;
					$display("%0s: branch reported with none outstanding", test_name);
				end else begin
					br_exp = br_q.pop_front();
					if (br_exp !== {br_warp, br_taken, br_dest}) begin
						errors++;
						$display("CHECK FAILED %0s: branch expected %h actual %h", test_name,
							br_exp, {br_warp, br_taken, br_dest});
					end
				end
			end
			if (wb_cyc && wb_stb && wb_ack)
				mem_acked++;
			if (count_check && (wb_seen != wb_expected)) begin
				errors++;
				$display("CHECK FAILED %0s: writeback count expected %0d actual %0d",
					test_name, wb_expected, wb_seen);
			end

			// ########################################
			// accepted instructions, in program order
			// ########################################
			if (in_valid && in_ready) begin
				op_a = ref_rf[in_warp][in_rs1];
				op_b = ref_rf[in_warp][in_rs2];
				addr = op_a + in_imm;
				case (in_op)
					OP_SW: begin
						ref_mem[addr[9:2]] = op_b;
						mem_issued++;
					end
					OP_BEQ: br_q.push_back({in_warp, op_a == op_b, in_pc + in_imm});
					OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LW: begin
						if (in_op == OP_LW)
							mem_issued++;
						result = expect_result(in_op, op_a, op_b, in_imm, ref_mem[addr[9:2]]);
						// register 0 stays zero and never reaches writeback
						if (in_rd != '0) begin
							ref_rf[in_warp][in_rd] = result;
							res_q.push_back({in_warp, in_rd, result});
							wb_expected++;
						end
					end
					default: begin
						errors++;
						$display("%0s: illegal opcode %0d accepted", test_name, in_op);
					end
				endcase
			end
			outstanding = res_q.size() + br_q.size() + mem_issued - mem_acked;
		end
	end

endmodule

/* test/data_mem_model.sv */
`timescale 1ns/1ps

module data_mem_model (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     cyc,
	input  logic                     stb,
	input  logic                     we,
	input  logic [bk_pkg::XLEN-1:0]   adr,
	input  logic [bk_pkg::XLEN-1:0]   dat_w,
	input  logic [bk_pkg::SEL_W-1:0]  sel,
	output logic [bk_pkg::XLEN-1:0]   dat_r,
	output logic                     ack
);
	import bk_pkg::*;

	logic [XLEN-1:0] mem [256];
	logic [XLEN-1:0] word;
	logic pending;
	int unsigned wait_cnt;
	int unsigned delay;

	// every word starts with a value derived from its own index
	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = 32'hd00d_0000 ^ (i * 32'h0001_0103);
		end
	end

	// the first cycle of a request draws how many more cycles ack waits
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack      <= 1'b0;
			pending  <= 1'b0;
			wait_cnt <= 0;
			dat_r    <= '0;
		end else begin
			ack <= 1'b0;
			if (cyc && stb && !ack) begin
				if (pending)
					delay = wait_cnt;
				else
					delay = $urandom_range(3, 0);
				if (delay == 0) begin
					ack     <= 1'b1;
					pending <= 1'b0;
					if (we) begin
						word = mem[adr[9:2]];
						for (int b = 0; b < SEL_W; b++) begin
							if (sel[b])
								word[8*b +: 8] = dat_w[8*b +: 8];
						end
						mem[adr[9:2]] <= word;
					end else begin
						dat_r <= mem[adr[9:2]];
					end
				end else begin
					pending  <= 1'b1;
					wait_cnt <= delay - 1;
				end
			end
		end
	end

endmodule

/* rtl/back_end.sv */
`timescale 1ns/1ps

module back_end (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     in_valid,
	input  logic [bk_pkg::WARP_W-1:0] in_warp,
	input  logic [bk_pkg::OP_W-1:0]   in_op,
	input  logic [bk_pkg::REG_W-1:0]  in_rd,
	input  logic [bk_pkg::REG_W-1:0]  in_rs1,
	input  logic [bk_pkg::REG_W-1:0]  in_rs2,
	input  logic [bk_pkg::XLEN-1:0]   in_imm,
	input  logic [bk_pkg::XLEN-1:0]   in_pc,
	output logic                     in_ready,
	output logic                     br_valid,
	output logic [bk_pkg::WARP_W-1:0] br_warp,
	output logic                     br_taken,
	output logic [bk_pkg::XLEN-1:0]   br_dest,
	output logic                     wb_valid,
	output logic [bk_pkg::WARP_W-1:0] wb_warp,
	output logic [bk_pkg::REG_W-1:0]  wb_rd,
	output logic [bk_pkg::XLEN-1:0]   wb_data,
	output logic                     wb_cyc,
	output logic                     wb_stb,
	output logic                     wb_we,
	output logic [bk_pkg::XLEN-1:0]   wb_adr,
	output logic [bk_pkg::XLEN-1:0]   wb_dat_w,
	output logic [bk_pkg::SEL_W-1:0]  wb_sel,
	input  logic [bk_pkg::XLEN-1:0]   wb_dat_r,
	input  logic                     wb_ack
);
	import bk_pkg::*;

	// ########################################
	// dispatch and result wires
	// ########################################

	logic ex_valid, ex_ready;
	logic [OP_W-1:0] ex_op;
	logic [WARP_W-1:0] ex_warp;
	logic [REG_W-1:0] ex_rd;
	logic [XLEN-1:0] ex_a, ex_b, ex_imm, ex_pc;
	logic ls_valid, ls_ready, ls_store;
	logic [WARP_W-1:0] ls_warp;
	logic [REG_W-1:0] ls_rd;
	logic [XLEN-1:0] ls_addr, ls_wdata;
	logic ex_res_valid, ex_res_take;
	logic [WARP_W-1:0] ex_res_warp;
	logic [REG_W-1:0] ex_res_rd;
	logic [XLEN-1:0] ex_res_data;
	logic mem_res_valid, mem_res_take;
	logic [WARP_W-1:0] mem_res_warp;
	logic [REG_W-1:0] mem_res_rd;
	logic [XLEN-1:0] mem_res_data;

	gpr_stage u_gpr_stage (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_valid (in_valid),
		.in_warp  (in_warp),
		.in_op    (in_op),
		.in_rd    (in_rd),
		.in_rs1   (in_rs1),
		.in_rs2   (in_rs2),
		.in_imm   (in_imm),
		.in_pc    (in_pc),
		.ex_ready (ex_ready),
		.ls_ready (ls_ready),
		.wb_valid (wb_valid),
		.wb_warp  (wb_warp),
		.wb_rd    (wb_rd),
		.wb_data  (wb_data),
		.in_ready (in_ready),
		.ex_valid (ex_valid),
		.ex_op    (ex_op),
		.ex_warp  (ex_warp),
		.ex_rd    (ex_rd),
		.ex_a     (ex_a),
		.ex_b     (ex_b),
		.ex_imm   (ex_imm),
		.ex_pc    (ex_pc),
		.ls_valid (ls_valid),
		.ls_store (ls_store),
		.ls_warp  (ls_warp),
		.ls_rd    (ls_rd),
		.ls_addr  (ls_addr),
		.ls_wdata (ls_wdata)
	);

	exec_unit u_exec_unit (
		.clk          (clk),
		.arst_n       (arst_n),
		.ex_valid     (ex_valid),
		.ex_op        (ex_op),
		.ex_warp      (ex_warp),
		.ex_rd        (ex_rd),
		.ex_a         (ex_a),
		.ex_b         (ex_b),
		.ex_imm       (ex_imm),
		.ex_pc        (ex_pc),
		.ex_res_take  (ex_res_take),
		.ex_ready     (ex_ready),
		.ex_res_valid (ex_res_valid),
		.ex_res_warp  (ex_res_warp),
		.ex_res_rd    (ex_res_rd),
		.ex_res_data  (ex_res_data),
		.br_valid     (br_valid),
		.br_warp      (br_warp),
		.br_taken     (br_taken),
		.br_dest      (br_dest)
	);

	lsu u_lsu (
		.clk           (clk),
		.arst_n        (arst_n),
		.ls_valid      (ls_valid),
		.ls_store      (ls_store),
		.ls_warp       (ls_warp),
		.ls_rd         (ls_rd),
		.ls_addr       (ls_addr),
		.ls_wdata      (ls_wdata),
		.mem_res_take  (mem_res_take),
		.wb_dat_r      (wb_dat_r),
		.wb_ack        (wb_ack),
		.ls_ready      (ls_ready),
		.mem_res_valid (mem_res_valid),
		.mem_res_warp  (mem_res_warp),
		.mem_res_rd    (mem_res_rd),
		.mem_res_data  (mem_res_data),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_we         (wb_we),
		.wb_adr        (wb_adr),
		.wb_dat_w      (wb_dat_w),
		.wb_sel        (wb_sel)
	);

	writeback u_writeback (
		.clk           (clk),
		.arst_n        (arst_n),
		.ex_res_valid  (ex_res_valid),
		.ex_res_warp   (ex_res_warp),
		.ex_res_rd     (ex_res_rd),
		.ex_res_data   (ex_res_data),
		.mem_res_valid (mem_res_valid),
		.mem_res_warp  (mem_res_warp),
		.mem_res_rd    (mem_res_rd),
		.mem_res_data  (mem_res_data),
		.ex_res_take   (ex_res_take),
		.mem_res_take  (mem_res_take),
		.wb_valid      (wb_valid),
		.wb_warp       (wb_warp),
		.wb_rd         (wb_rd),
		.wb_data       (wb_data)
	);

endmodule

/* rtl/writeback.sv */
`timescale 1ns/1ps

module writeback (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     ex_res_valid,
	input  logic [bk_pkg::WARP_W-1:0] ex_res_warp,
	input  logic [bk_pkg::REG_W-1:0]  ex_res_rd,
	input  logic [bk_pkg::XLEN-1:0]   ex_res_data,
	input  logic                     mem_res_valid,
	input  logic [bk_pkg::WARP_W-1:0] mem_res_warp,
	input  logic [bk_pkg::REG_W-1:0]  mem_res_rd,
	input  logic [bk_pkg::XLEN-1:0]   mem_res_data,
	output logic                     ex_res_take,
	output logic                     mem_res_take,
	output logic                     wb_valid,
	output logic [bk_pkg::WARP_W-1:0] wb_warp,
	output logic [bk_pkg::REG_W-1:0]  wb_rd,
	output logic [bk_pkg::XLEN-1:0]   wb_data
);

	// memory wins, the execute result waits in its own slot
	assign mem_res_take = mem_res_valid;
	assign ex_res_take  = ex_res_valid && !mem_res_valid;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid <= 1'b0;
			wb_warp  <= '0;
			wb_rd    <= '0;
			wb_data  <= '0;
		end else begin
			wb_valid <= mem_res_take || ex_res_take;
			if (mem_res_take) begin
				wb_warp <= mem_res_warp;
				wb_rd   <= mem_res_rd;
				wb_data <= mem_res_data;
			end else if (ex_res_take) begin
				wb_warp <= ex_res_warp;
				wb_rd   <= ex_res_rd;
				wb_data <= ex_res_data;
			end
		end
	end

endmodule

/* rtl/lsu.sv */
`timescale 1ns/1ps

module lsu (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     ls_valid,
	input  logic                     ls_store,
	input  logic [bk_pkg::WARP_W-1:0] ls_warp,
	input  logic [bk_pkg::REG_W-1:0]  ls_rd,
	input  logic [bk_pkg::XLEN-1:0]   ls_addr,
	input  logic [bk_pkg::XLEN-1:0]   ls_wdata,
	input  logic                     mem_res_take,
	input  logic [bk_pkg::XLEN-1:0]   wb_dat_r,
	input  logic                     wb_ack,
	output logic                     ls_ready,
	output logic                     mem_res_valid,
	output logic [bk_pkg::WARP_W-1:0] mem_res_warp,
	output logic [bk_pkg::REG_W-1:0]  mem_res_rd,
	output logic [bk_pkg::XLEN-1:0]   mem_res_data,
	output logic                     wb_cyc,
	output logic                     wb_stb,
	output logic                     wb_we,
	output logic [bk_pkg::XLEN-1:0]   wb_adr,
	output logic [bk_pkg::XLEN-1:0]   wb_dat_w,
	output logic [bk_pkg::SEL_W-1:0]  wb_sel
);
	import bk_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_bus,
		st_result
	} ls_state_t;

	ls_state_t state;
	logic req_store;
	logic [WARP_W-1:0] req_warp;
	logic [REG_W-1:0] req_rd;
	logic [XLEN-1:0] req_addr;
	logic [XLEN-1:0] req_wdata;

	// cyc and stb follow the state, so they drop on the cycle after ack
	assign ls_ready      = (state == st_idle);
	assign wb_cyc        = (state == st_bus);
	assign wb_stb        = (state == st_bus);
	assign wb_we         = req_store;
	assign wb_adr        = req_addr;
	assign wb_dat_w      = req_wdata;
	assign wb_sel        = '1;
	assign mem_res_valid = (state == st_result);
	assign mem_res_warp  = req_warp;
	assign mem_res_rd    = req_rd;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state        <= st_idle;
			req_store    <= 1'b0;
			req_warp     <= '0;
			req_rd       <= '0;
			req_addr     <= '0;
			req_wdata    <= '0;
			mem_res_data <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (ls_valid) begin
						req_store <= ls_store;
						req_warp  <= ls_warp;
						req_rd    <= ls_rd;
						req_addr  <= ls_addr;
						req_wdata <= ls_wdata;
						state     <= st_bus;
					end
				end
				st_bus: begin
					// stores and loads into r0 have nothing to write back
					if (wb_ack) begin
						if (!req_store && (req_rd != '0)) begin
							mem_res_data <= wb_dat_r;
							state        <= st_result;
						end else begin
							state <= st_idle;
						end
					end
				end
				st_result: begin
					if (mem_res_take)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

/* rtl/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     ex_valid,
	input  logic [bk_pkg::OP_W-1:0]   ex_op,
	input  logic [bk_pkg::WARP_W-1:0] ex_warp,
	input  logic [bk_pkg::REG_W-1:0]  ex_rd,
	input  logic [bk_pkg::XLEN-1:0]   ex_a,
	input  logic [bk_pkg::XLEN-1:0]   ex_b,
	input  logic [bk_pkg::XLEN-1:0]   ex_imm,
	input  logic [bk_pkg::XLEN-1:0]   ex_pc,
	input  logic                     ex_res_take,
	output logic                     ex_ready,
	output logic                     ex_res_valid,
	output logic [bk_pkg::WARP_W-1:0] ex_res_warp,
	output logic [bk_pkg::REG_W-1:0]  ex_res_rd,
	output logic [bk_pkg::XLEN-1:0]   ex_res_data,
	output logic                     br_valid,
	output logic [bk_pkg::WARP_W-1:0] br_warp,
	output logic                     br_taken,
	output logic [bk_pkg::XLEN-1:0]   br_dest
);
	import bk_pkg::*;

	logic accept;
	logic is_branch;
	logic writes;
	logic [XLEN-1:0] alu_res;

	// the result slot frees up in the same cycle writeback takes it
	assign ex_ready  = !ex_res_valid || ex_res_take;
	assign accept    = ex_valid && ex_ready;
	assign is_branch = (ex_op == OP_BEQ);
	assign writes    = op_writes_rd(ex_op) && (ex_rd != '0);

	always_comb begin
		case (ex_op)
			OP_ADD:  alu_res = ex_a + ex_b;
			OP_SUB:  alu_res = ex_a - ex_b;
			OP_AND:  alu_res = ex_a & ex_b;
			OP_OR:   alu_res = ex_a | ex_b;
			OP_XOR:  alu_res = ex_a ^ ex_b;
			OP_ADDI: alu_res = ex_a + ex_imm;
			default: alu_res = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_res_valid <= 1'b0;
			ex_res_warp  <= '0;
			ex_res_rd    <= '0;
			ex_res_data  <= '0;
			br_valid     <= 1'b0;
			br_warp      <= '0;
			br_taken     <= 1'b0;
			br_dest      <= '0;
		end else begin
			br_valid <= accept && is_branch;
			if (accept && is_branch) begin
				br_warp  <= ex_warp;
				br_taken <= (ex_a == ex_b);
				br_dest  <= ex_pc + ex_imm;
			end
			if (accept && writes) begin
				ex_res_valid <= 1'b1;
				ex_res_warp  <= ex_warp;
				ex_res_rd    <= ex_rd;
				ex_res_data  <= alu_res;
			end else if (ex_res_take) begin
				ex_res_valid <= 1'b0;
			end
		end
	end

endmodule

/* rtl/gpr_stage.sv */
`timescale 1ns/1ps

module gpr_stage (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     in_valid,
	input  logic [bk_pkg::WARP_W-1:0] in_warp,
	input  logic [bk_pkg::OP_W-1:0]   in_op,
	input  logic [bk_pkg::REG_W-1:0]  in_rd,
	input  logic [bk_pkg::REG_W-1:0]  in_rs1,
	input  logic [bk_pkg::REG_W-1:0]  in_rs2,
	input  logic [bk_pkg::XLEN-1:0]   in_imm,
	input  logic [bk_pkg::XLEN-1:0]   in_pc,
	input  logic                     ex_ready,
	input  logic                     ls_ready,
	input  logic                     wb_valid,
	input  logic [bk_pkg::WARP_W-1:0] wb_warp,
	input  logic [bk_pkg::REG_W-1:0]  wb_rd,
	input  logic [bk_pkg::XLEN-1:0]   wb_data,
	output logic                     in_ready,
	output logic                     ex_valid,
	output logic [bk_pkg::OP_W-1:0]   ex_op,
	output logic [bk_pkg::WARP_W-1:0] ex_warp,
	output logic [bk_pkg::REG_W-1:0]  ex_rd,
	output logic [bk_pkg::XLEN-1:0]   ex_a,
	output logic [bk_pkg::XLEN-1:0]   ex_b,
	output logic [bk_pkg::XLEN-1:0]   ex_imm,
	output logic [bk_pkg::XLEN-1:0]   ex_pc,
	output logic                     ls_valid,
	output logic                     ls_store,
	output logic [bk_pkg::WARP_W-1:0] ls_warp,
	output logic [bk_pkg::REG_W-1:0]  ls_rd,
	output logic [bk_pkg::XLEN-1:0]   ls_addr,
	output logic [bk_pkg::XLEN-1:0]   ls_wdata
);
	import bk_pkg::*;

	logic [XLEN-1:0] rf [NUM_WARPS][NUM_REGS];
	logic [NUM_WARPS-1:0][NUM_REGS-1:0] busy;
	logic [NUM_REGS-1:0] wb_clr_mask;
	logic [NUM_REGS-1:0] warp_busy;
	logic run;
	logic is_mem;
	logic writes_rd;
	logic unit_ok;
	logic fire;
	logic [XLEN-1:0] rs1_val;
	logic [XLEN-1:0] rs2_val;

	// register read with bypass of the writeback happening in this cycle
	always_comb begin
		if (in_rs1 == '0)
			rs1_val = '0;
		else if (wb_valid && (wb_warp == in_warp) && (wb_rd == in_rs1))
			rs1_val = wb_data;
		else
			rs1_val = rf[in_warp][in_rs1];
		if (in_rs2 == '0)
			rs2_val = '0;
		else if (wb_valid && (wb_warp == in_warp) && (wb_rd == in_rs2))
			rs2_val = wb_data;
		else
			rs2_val = rf[in_warp][in_rs2];
	end

	// ########################################
	// scoreboard check and issue
	// ########################################

	always_comb begin
		wb_clr_mask = '0;
		if (wb_valid && (wb_warp == in_warp))
			wb_clr_mask[wb_rd] = 1'b1;
	end

	// a register freed by this cycle's writeback no longer blocks issue
	assign warp_busy = busy[in_warp] & ~wb_clr_mask;
	assign is_mem    = op_is_mem(in_op);
	assign writes_rd = op_writes_rd(in_op) && (in_rd != '0);
	assign unit_ok   = is_mem ? (!ls_valid || ls_ready) : (!ex_valid || ex_ready);

	assign in_ready = run && unit_ok && !warp_busy[in_rs1]
		&& !(op_uses_rs2(in_op) && warp_busy[in_rs2])
		&& !(writes_rd && warp_busy[in_rd]);

	assign fire = in_valid && in_ready;

	// ########################################
	// register file and busy bits
	// ########################################

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			run  <= 1'b0;
			busy <= '0;
			for (int w = 0; w < NUM_WARPS; w++) begin
				for (int r = 0; r < NUM_REGS; r++) begin
					rf[w][r] <= '0;
				end
			end
		end else begin
			run <= 1'b1;
			if (wb_valid && (wb_rd != '0)) begin
				rf[wb_warp][wb_rd]   <= wb_data;
				busy[wb_warp][wb_rd] <= 1'b0;
			end
			// issue comes last so a new owner of the register wins
			if (fire && writes_rd)
				busy[in_warp][in_rd] <= 1'b1;
		end
	end

	// ########################################
	// dispatch registers
	// ########################################

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid <= 1'b0;
			ex_op    <= '0;
			ex_warp  <= '0;
			ex_rd    <= '0;
			ex_a     <= '0;
			ex_b     <= '0;
			ex_imm   <= '0;
			ex_pc    <= '0;
			ls_valid <= 1'b0;
			ls_store <= 1'b0;
			ls_warp  <= '0;
			ls_rd    <= '0;
			ls_addr  <= '0;
			ls_wdata <= '0;
		end else begin
			if (fire && !is_mem) begin
				ex_valid <= 1'b1;
				ex_op    <= in_op;
				ex_warp  <= in_warp;
				ex_rd    <= in_rd;
				ex_a     <= rs1_val;
				ex_b     <= rs2_val;
				ex_imm   <= in_imm;
				ex_pc    <= in_pc;
			end else if (ex_ready) begin
				ex_valid <= 1'b0;
			end
			if (fire && is_mem) begin
				ls_valid <= 1'b1;
				ls_store <= (in_op == OP_SW);
				ls_warp  <= in_warp;
				ls_rd    <= in_rd;
				ls_addr  <= rs1_val + in_imm;
				ls_wdata <= rs2_val;
			end else if (ls_ready) begin
				ls_valid <= 1'b0;
			end
		end
	end

endmodule

/* rtl/bk_pkg.sv */
package bk_pkg;

	// ########################################
	// widths and sizes
	// ########################################

	localparam int XLEN      = 32;
	localparam int NUM_WARPS = 4;
	localparam int WARP_W    = 2;
	localparam int NUM_REGS  = 8;
	localparam int REG_W     = 3;
	localparam int OP_W      = 4;
	localparam int SEL_W     = XLEN / 8;

	// ########################################
	// opcodes
	// ########################################

	localparam logic [OP_W-1:0] OP_ADD  = 4'd0;
	localparam logic [OP_W-1:0] OP_SUB  = 4'd1;
	localparam logic [OP_W-1:0] OP_AND  = 4'd2;
	localparam logic [OP_W-1:0] OP_OR   = 4'd3;
	localparam logic [OP_W-1:0] OP_XOR  = 4'd4;
	localparam logic [OP_W-1:0] OP_ADDI = 4'd5;
	localparam logic [OP_W-1:0] OP_LW   = 4'd6;
	localparam logic [OP_W-1:0] OP_SW   = 4'd7;
	localparam logic [OP_W-1:0] OP_BEQ  = 4'd8;

	// loads and stores go to the lsu, everything else to the execute unit
	function automatic logic op_is_mem(input logic [OP_W-1:0] op);
		return (op == OP_LW) || (op == OP_SW);
	endfunction

	function automatic logic op_uses_rs2(input logic [OP_W-1:0] op);
		return (op <= OP_XOR) || (op == OP_SW) || (op == OP_BEQ);
	endfunction

	// true for every opcode that produces a register result
	function automatic logic op_writes_rd(input logic [OP_W-1:0] op);
		return (op <= OP_ADDI) || (op == OP_LW);
	endfunction

endpackage
